// File: logic/cpuPkg.sv
package cpuPkg;

    localparam int wordWidth = 16;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        func_e      func;
    } rFormat_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;    // signed offset or constant
    } iFormat_t;

    // same word, two field layouts
    typedef union packed {
        rFormat_t rFmt;
        iFormat_t iFmt;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_EQ,
        ALU_NE
    } aluOp_e;

    typedef struct packed {
        aluOp_e     aluOp;
        logic       useImm;     // operand b from immediate
        logic       regWrite;
        logic [1:0] destReg;
        logic       memRead;
        logic       memWrite;
        logic       isBranch;
        logic       isWwd;
        logic       isHalt;
    } ctrl_t;

    typedef struct packed {
        logic [wordWidth-1:0] pc;
        instr_t               instr;
        logic                 valid;
    } fetchOut_t;

    typedef struct packed {
        logic [wordWidth-1:0] result;
        logic [1:0]           destReg;
        logic                 regWrite;
        logic                 isWwd;
        logic                 isHalt;
        logic                 valid;
    } wbIn_t;

    typedef struct packed {
        logic [wordWidth-1:0] addr;
        logic [wordWidth-1:0] wdata;
        logic                 write;    // 0 for load
    } memReq_t;

endpackage

// File: logic/instrFetch.sv
module instrFetch #(
    parameter logic [cpuPkg::wordWidth-1:0] resetPc = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         flush,
    input  logic [cpuPkg::wordWidth-1:0] target,
    output logic [cpuPkg::wordWidth-1:0] instrAddr,
    input  cpuPkg::instr_t               instrData,
    output cpuPkg::fetchOut_t            fetchOut
);
    import cpuPkg::*;

    logic [wordWidth-1:0] pc;

    assign instrAddr = pc;  // memory answers in the same cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (flush) begin
            pc <= target;   // redirect to branch target
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // fetch-to-execute register
    always_ff @(posedge clk) begin
        if (!stall) begin
            fetchOut.pc    <= pc;
            fetchOut.instr <= instrData;
        end
        if (rst) begin
            fetchOut.valid <= 1'b0;
        end else if (flush) begin
            fetchOut.valid <= 1'b0;     // wrong-path slot dropped
        end else if (!stall) begin
            fetchOut.valid <= 1'b1;
        end
    end

endmodule

// File: logic/regFile.sv
module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [1:0]                   rdAddrA,
    input  logic [1:0]                   rdAddrB,
    output logic [cpuPkg::wordWidth-1:0] rdDataA,
    output logic [cpuPkg::wordWidth-1:0] rdDataB,
    input  logic                         wrEn,
    input  logic [1:0]                   wrAddr,
    input  logic [cpuPkg::wordWidth-1:0] wrData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] regs [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 4; k++) begin
                regs[k] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // writeback value bypasses the array
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// File: logic/controlDecoder.sv
module controlDecoder (
    input  cpuPkg::instr_t               instr,
    output cpuPkg::ctrl_t                ctrl,
    output logic [cpuPkg::wordWidth-1:0] imm
);
    import cpuPkg::*;

    // 8-bit immediate, sign extended
    assign imm = {{(wordWidth - 8){instr.iFmt.imm[7]}}, instr.iFmt.imm};

    always_comb begin
        ctrl       = '0;    // no-op unless recognised
        ctrl.aluOp = ALU_ADD;
        if (instr.rFmt.opcode == OP_RTYPE) begin
            case (instr.rFmt.func)
                FN_ADD: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.destReg  = instr.rFmt.rd;
                end
                FN_SUB: begin
                    ctrl.aluOp    = ALU_SUB;
                    ctrl.regWrite = 1'b1;
                    ctrl.destReg  = instr.rFmt.rd;
                end
                FN_AND: begin
                    ctrl.aluOp    = ALU_AND;
                    ctrl.regWrite = 1'b1;
                    ctrl.destReg  = instr.rFmt.rd;
                end
                FN_ORR: begin
                    ctrl.aluOp    = ALU_OR;
                    ctrl.regWrite = 1'b1;
                    ctrl.destReg  = instr.rFmt.rd;
                end
                FN_WWD:  ctrl.isWwd  = 1'b1;   // rs goes to output port
                FN_HLT:  ctrl.isHalt = 1'b1;
                default: ;
            endcase
        end else begin
            case (instr.iFmt.opcode)
                OP_ADI: begin
                    ctrl.useImm   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.destReg  = instr.iFmt.rt;
                end
                OP_LWD: begin
                    ctrl.useImm   = 1'b1;   // address = rs + imm
                    ctrl.regWrite = 1'b1;
                    ctrl.destReg  = instr.iFmt.rt;
                    ctrl.memRead  = 1'b1;
                end
                OP_SWD: begin
                    ctrl.useImm   = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
                OP_BNE: begin
                    ctrl.aluOp    = ALU_NE;
                    ctrl.isBranch = 1'b1;
                end
                OP_BEQ: begin
                    ctrl.aluOp    = ALU_EQ;
                    ctrl.isBranch = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: logic/alu.sv
module alu (
    input  logic [cpuPkg::wordWidth-1:0] a,
    input  logic [cpuPkg::wordWidth-1:0] b,
    input  cpuPkg::aluOp_e               op,
    output logic [cpuPkg::wordWidth-1:0] result,
    output logic                         condTrue
);
    import cpuPkg::*;

    logic [wordWidth-1:0] diff;

    assign diff = a - b;

    always_comb begin
        result   = '0;
        condTrue = 1'b0;
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_EQ: begin
                result   = diff;
                condTrue = (diff == '0);    // operands equal
            end
            ALU_NE: begin
                result   = diff;
                condTrue = (diff != '0);
            end
            default: ;
        endcase
    end

endmodule

// File: logic/executeStage.sv
module executeStage (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::fetchOut_t            fetchOut,
    input  cpuPkg::ctrl_t                ctrl,
    input  logic [cpuPkg::wordWidth-1:0] imm,
    input  logic [cpuPkg::wordWidth-1:0] rdDataA,
    input  logic [cpuPkg::wordWidth-1:0] rdDataB,
    input  logic [cpuPkg::wordWidth-1:0] aluResult,
    input  logic                         condTrue,
    output logic [cpuPkg::wordWidth-1:0] aluA,
    output logic [cpuPkg::wordWidth-1:0] aluB,
    output logic                         stall,
    output logic                         flush,
    output logic [cpuPkg::wordWidth-1:0] target,
    output cpuPkg::memReq_t              memReq,
    output logic                         memReqValid,
    input  logic                         memReqReady,
    input  logic [cpuPkg::wordWidth-1:0] memRespData,
    input  logic                         memRespValid,
    output cpuPkg::wbIn_t                wbIn
);
    import cpuPkg::*;

    typedef enum logic {MEM_IDLE, MEM_WAIT} memState_e;

    memState_e memState;
    logic      haltSeen;
    logic      live;        // real instruction in execute
    logic      memStall;
    logic      advance;

    assign live   = fetchOut.valid && !haltSeen;
    assign aluA   = rdDataA;
    assign aluB   = ctrl.useImm ? imm : rdDataB;
    assign target = fetchOut.pc + 1'b1 + imm;
    assign flush  = live && ctrl.isBranch && condTrue;

    // request payload held steady by the stall
    assign memReqValid = live && (ctrl.memRead || ctrl.memWrite) && memState == MEM_IDLE;
    always_comb begin
        memReq.addr  = aluResult;
        memReq.wdata = rdDataB;
        memReq.write = ctrl.memWrite;
    end

    always_comb begin
        if (memState == MEM_WAIT) begin
            memStall = !memRespValid;
        end else begin
            memStall = memReqValid && (ctrl.memRead || !memReqReady);
        end
    end

    assign stall   = memStall || haltSeen || (live && ctrl.isHalt);
    assign advance = live && !memStall;

    always_ff @(posedge clk) begin
        if (rst) begin
            memState <= MEM_IDLE;
        end else if (memState == MEM_IDLE) begin
            if (memReqValid && memReqReady && ctrl.memRead) begin
                memState <= MEM_WAIT;   // load accepted, await data
            end
        end else if (memRespValid) begin
            memState <= MEM_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            haltSeen <= 1'b0;
        end else if (live && ctrl.isHalt) begin
            haltSeen <= 1'b1;   // stays until reset
        end
    end

    // execute-to-writeback register
    always_ff @(posedge clk) begin
        if (ctrl.memRead) begin
            wbIn.result <= memRespData;
        end else if (ctrl.isWwd) begin
            wbIn.result <= rdDataA;
        end else begin
            wbIn.result <= aluResult;
        end
        wbIn.destReg  <= ctrl.destReg;
        wbIn.regWrite <= ctrl.regWrite;
        wbIn.isWwd    <= ctrl.isWwd;
        wbIn.isHalt   <= ctrl.isHalt;
        if (rst) begin
            wbIn.valid <= 1'b0;
        end else begin
            wbIn.valid <= advance;  // bubble while stalled
        end
    end

endmodule

// File: logic/writebackStage.sv
module writebackStage (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::wbIn_t                wbIn,
    output logic                         wrEn,
    output logic [1:0]                   wrAddr,
    output logic [cpuPkg::wordWidth-1:0] wrData,
    output logic [cpuPkg::wordWidth-1:0] outPort,
    output logic                         outValid,
    output logic [cpuPkg::wordWidth-1:0] numInst,
    output logic                         halted
);
    import cpuPkg::*;

    logic wwdRetire;

    assign wrEn      = wbIn.valid && wbIn.regWrite;
    assign wrAddr    = wbIn.destReg;
    assign wrData    = wbIn.result;
    assign wwdRetire = wbIn.valid && wbIn.isWwd;

    always_ff @(posedge clk) begin
        if (wwdRetire) begin
            outPort <= wbIn.result;
        end
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= wwdRetire;  // single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            numInst <= '0;
            halted  <= 1'b0;
        end else if (wbIn.valid) begin
            numInst <= numInst + 1'b1;  // every retired slot
            if (wbIn.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: logic/cpuCore.sv
module cpuCore #(
    parameter logic [cpuPkg::wordWidth-1:0] resetPc = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic [cpuPkg::wordWidth-1:0] instrAddr,
    input  cpuPkg::instr_t               instrData,
    output cpuPkg::memReq_t              memReq,
    output logic                         memReqValid,
    input  logic                         memReqReady,
    input  logic [cpuPkg::wordWidth-1:0] memRespData,
    input  logic                         memRespValid,
    output logic [cpuPkg::wordWidth-1:0] outPort,
    output logic                         outValid,
    output logic [cpuPkg::wordWidth-1:0] numInst,
    output logic                         halted
);
    import cpuPkg::*;

    fetchOut_t            fetchOut;
    ctrl_t                ctrl;
    wbIn_t                wbIn;
    logic [wordWidth-1:0] imm, target, rdDataA, rdDataB, aluA, aluB, aluResult, wrData;
    logic                 condTrue, stall, flush, wrEn;
    logic [1:0]           wrAddr;

    instrFetch #(.resetPc(resetPc)) i_instrFetch (
        .clk, .rst, .stall, .flush, .target, .instrAddr, .instrData, .fetchOut
    );

    regFile i_regFile (
        .clk, .rst,
        .rdAddrA(fetchOut.instr.iFmt.rs),   // rs
        .rdAddrB(fetchOut.instr.iFmt.rt),   // rt
        .rdDataA, .rdDataB, .wrEn, .wrAddr, .wrData
    );

    controlDecoder i_controlDecoder (.instr(fetchOut.instr), .ctrl, .imm);

    alu i_alu (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .condTrue);

    executeStage i_executeStage (
        .clk, .rst, .fetchOut, .ctrl, .imm, .rdDataA, .rdDataB, .aluResult, .condTrue,
        .aluA, .aluB, .stall, .flush, .target, .memReq, .memReqValid, .memReqReady,
        .memRespData, .memRespValid, .wbIn
    );

    writebackStage i_writebackStage (
        .clk, .rst, .wbIn, .wrEn, .wrAddr, .wrData, .outPort, .outValid, .numInst, .halted
    );

endmodule

// File: verification/clockGen.sv
module clockGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;     // period 40
        end
    end

endmodule

// File: verification/dataMemModel.sv
module dataMemModel (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::memReq_t              memReq,
    input  logic                         memReqValid,
    output logic                         memReqReady,
    output logic [cpuPkg::wordWidth-1:0] memRespData,
    output logic                         memRespValid
);
    import cpuPkg::*;

    logic [wordWidth-1:0] mem [65536];
    int                   seed;
    int                   readyDelay;
    int                   respDelay;
    logic                 respPending;
    logic                 filled;
    logic [wordWidth-1:0] pendData;

    function automatic int nextDelay();
        int r;
        r = $random(seed);
        return r & 3;   // 0 to 3 cycles
    endfunction

    task automatic fillMem();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = (16'(a) * 16'h9e37) ^ 16'h5a5a;   // every address bit matters
        end
    endtask

    // outputs change on the falling edge only
    initial begin
        seed         = 32'ha6b98e30;
        memReqReady  = 1'b0;
        memRespValid = 1'b0;
        memRespData  = '0;
        respPending  = 1'b0;
        filled       = 1'b0;
        pendData     = '0;
        respDelay    = 0;
        readyDelay   = nextDelay();
        forever begin
            @(negedge clk);
            memRespValid = 1'b0;
            if (rst) begin
                memReqReady = 1'b0;
                respPending = 1'b0;
                if (!filled) begin
                    fillMem();
                end
                filled = 1'b1;
            end else begin
                filled = 1'b0;
                if (respPending) begin
                    if (respDelay == 0) begin
                        memRespValid = 1'b1;
                        memRespData  = pendData;
                        respPending  = 1'b0;
                    end else begin
                        respDelay--;
                    end
                end
                memReqReady = 1'b0;
                if (memReqValid && !respPending) begin
                    if (readyDelay == 0) begin
                        memReqReady = 1'b1;     // transfer at next rising edge
                        if (memReq.write) begin
                            mem[memReq.addr] = memReq.wdata;
                        end else begin
                            respPending = 1'b1;
                            pendData    = mem[memReq.addr];
                            respDelay   = nextDelay();
                        end
                        readyDelay = nextDelay();
                    end else begin
                        readyDelay--;
                    end
                end
            end
        end
    end

endmodule

// File: verification/cpuTb.sv
module cpuTb;
    import cpuPkg::*;

    logic                 clk;
    logic                 rst;
    logic [wordWidth-1:0] instrAddr;
    logic [wordWidth-1:0] memRespData;
    logic [wordWidth-1:0] outPort;
    logic [wordWidth-1:0] numInst;
    instr_t               instrData;
    memReq_t              memReq;
    logic                 memReqValid, memReqReady, memRespValid, outValid, halted;

    instr_t               instrMem [256];
    int                   seed;
    logic                 running;
    logic                 prevStalled;
    memReq_t              prevReq;
    logic [wordWidth-1:0] retired;
    logic [wordWidth-1:0] wwdQ [$];
    memReq_t              reqQ [$];
    logic [wordWidth-1:0] modelMem [logic [wordWidth-1:0]];

    assign instrData = instrMem[instrAddr[7:0]];    // combinational instruction port

    clockGen i_clockGen (.clk);

    cpuCore #(.resetPc(16'h0000)) i_cpuCore (
        .clk, .rst, .instrAddr, .instrData, .memReq, .memReqValid, .memReqReady,
        .memRespData, .memRespValid, .outPort, .outValid, .numInst, .halted
    );

    dataMemModel i_dataMem (
        .clk, .rst, .memReq, .memReqValid, .memReqReady, .memRespData, .memRespValid
    );

    task automatic stopFail();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic reportError(string msg);
        $display("** Error at time %0t: %s", $time, msg);
        stopFail();
    endtask

    task automatic reportFailure(string msg);
        $display("%s", msg);
        stopFail();
    endtask

    task automatic checkWord(logic [wordWidth-1:0] actual, logic [wordWidth-1:0] expected,
                             string what);
        if (actual !== expected) begin
            reportError($sformatf("%s: got %h, expected %h", what, actual, expected));
        end
    endtask

    task automatic checkMemReq(memReq_t actual, memReq_t expected, string what);
        if (actual !== expected) begin
            reportError($sformatf("%s: got addr %h data %h write %b, expected %h %h %b",
                what, actual.addr, actual.wdata, actual.write,
                expected.addr, expected.wdata, expected.write));
        end
    endtask

    function automatic instr_t makeR(func_e fn, logic [1:0] rs, logic [1:0] rt, logic [1:0] rd);
        instr_t w;
        w.rFmt.opcode = OP_RTYPE;
        w.rFmt.rs     = rs;
        w.rFmt.rt     = rt;
        w.rFmt.rd     = rd;
        w.rFmt.func   = fn;
        return w;
    endfunction

    function automatic instr_t makeI(opcode_e op, logic [1:0] rs, logic [1:0] rt, logic [7:0] imm);
        instr_t w;
        w.iFmt.opcode = op;
        w.iFmt.rs     = rs;
        w.iFmt.rt     = rt;
        w.iFmt.imm    = imm;
        return w;
    endfunction

    function automatic func_e pickAluFunc(logic [1:0] sel);
        case (sel)
            2'd0:    return FN_ADD;
            2'd1:    return FN_SUB;
            2'd2:    return FN_AND;
            default: return FN_ORR;
        endcase
    endfunction

    function automatic logic [wordWidth-1:0] signExtend(logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    // initial contents of the data memory after reset
    function automatic logic [wordWidth-1:0] memFill(logic [wordWidth-1:0] a);
        return (a * 16'h9e37) ^ 16'h5a5a;
    endfunction

    function automatic logic [wordWidth-1:0] modelRead(logic [wordWidth-1:0] a);
        if (modelMem.exists(a)) begin
            return modelMem[a];
        end
        return memFill(a);
    endfunction

    task automatic genProgram(int len);
        int unsigned kind;
        logic [31:0] f;
        for (int i = 0; i < 256; i++) begin
            if (((i ^ len) & 1) == 0) begin
                instrMem[i] = makeR(FN_HLT, 2'd0, 2'd0, 2'd0);  // pad, HLT from len on
            end else begin
                instrMem[i] = makeR(FN_WWD, 2'd1, 2'd0, 2'd0);  // must never retire after HLT
            end
        end
        for (int i = 0; i < len; i++) begin
            kind = $random(seed);
            kind = kind % 10;
            f    = $random(seed);
            case (kind)
                0, 1, 2: instrMem[i] = makeR(pickAluFunc(f[9:8]), f[1:0], f[3:2], f[5:4]);
                3:       instrMem[i] = makeI(OP_ADI, f[1:0], f[3:2], f[15:8]);
                4:       instrMem[i] = makeI(OP_LWD, f[1:0], f[3:2], f[15:8]);
                5:       instrMem[i] = makeI(OP_SWD, f[1:0], f[3:2], f[15:8]);
                6, 7:    instrMem[i] = makeR(FN_WWD, f[1:0], f[3:2], f[5:4]);
                8:       instrMem[i] = makeI(OP_BEQ, f[1:0], f[3:2], {6'd0, f[9:8]});
                default: instrMem[i] = makeI(OP_BNE, f[1:0], f[3:2], {6'd0, f[9:8]});
            endcase
        end
    endtask

    // sequential ISA model, fills the expected queues
    task automatic runModel();
        logic [wordWidth-1:0] r [4];
        logic [wordWidth-1:0] pc, nextPc, addr;
        instr_t               w;
        memReq_t              req;
        logic                 done;
        int                   steps;
        for (int k = 0; k < 4; k++) begin
            r[k] = '0;
        end
        wwdQ.delete();
        reqQ.delete();
        modelMem.delete();
        retired = '0;
        pc      = '0;
        done    = 1'b0;
        steps   = 0;
        while (!done && steps < 1000) begin
            w       = instrMem[pc[7:0]];
            retired = retired + 16'd1;
            steps++;
            nextPc  = pc + 16'd1;
            addr    = r[w.iFmt.rs] + signExtend(w.iFmt.imm);
            if (w.rFmt.opcode == OP_RTYPE) begin
                case (w.rFmt.func)
                    FN_ADD:  r[w.rFmt.rd] = r[w.rFmt.rs] + r[w.rFmt.rt];
                    FN_SUB:  r[w.rFmt.rd] = r[w.rFmt.rs] - r[w.rFmt.rt];
                    FN_AND:  r[w.rFmt.rd] = r[w.rFmt.rs] & r[w.rFmt.rt];
                    FN_ORR:  r[w.rFmt.rd] = r[w.rFmt.rs] | r[w.rFmt.rt];
                    FN_WWD:  wwdQ.push_back(r[w.rFmt.rs]);
                    default: done = 1'b1;   // HLT
                endcase
            end else begin
                req.addr  = addr;
                req.wdata = r[w.iFmt.rt];
                req.write = (w.iFmt.opcode == OP_SWD);
                case (w.iFmt.opcode)
                    OP_ADI: r[w.iFmt.rt] = addr;
                    OP_LWD: begin
                        reqQ.push_back(req);
                        r[w.iFmt.rt] = modelRead(addr);
                    end
                    OP_SWD: begin
                        reqQ.push_back(req);
                        modelMem[addr] = r[w.iFmt.rt];
                    end
                    OP_BEQ: begin
                        if (r[w.iFmt.rs] == r[w.iFmt.rt]) begin
                            nextPc = nextPc + signExtend(w.iFmt.imm);
                        end
                    end
                    default: begin
                        if (r[w.iFmt.rs] != r[w.iFmt.rt]) begin
                            nextPc = nextPc + signExtend(w.iFmt.imm);
                        end
                    end
                endcase
            end
            pc = nextPc;
        end
        if (!done) begin
            reportFailure("reference model ran 1000 steps without reaching HLT");
        end
    endtask

    task automatic runProgram(int idx, int len);
        int cycles;
        genProgram(len);
        runModel();
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        checkWord({15'd0, outValid}, 16'd0, "outValid after reset");
        checkWord({15'd0, memReqValid}, 16'd0, "memReqValid after reset");
        checkWord({15'd0, halted}, 16'd0, "halted after reset");
        checkWord(numInst, 16'd0, "numInst after reset");
        running = 1'b1;
        cycles  = 0;
        while (!halted) begin
            if (cycles >= 3000) begin
                reportFailure($sformatf("timeout: program %0d never raised halted", idx));
            end
            @(negedge clk);
            cycles++;
        end
        repeat (8) @(negedge clk);      // watch for output after halt
        running = 1'b0;
        if (wwdQ.size() != 0) begin
            reportFailure($sformatf("program %0d ended with WWD outputs missing", idx));
        end
        if (reqQ.size() != 0) begin
            reportFailure($sformatf("program %0d ended with memory requests missing", idx));
        end
        checkWord({15'd0, halted}, 16'd1, "halted held after HLT");
        checkWord(numInst, retired, "retired instruction count");
        foreach (modelMem[a]) begin
            checkWord(i_dataMem.mem[a], modelMem[a], $sformatf("data memory at %h", a));
        end
    endtask

    // port monitor, sampled at the rising edge before any update
    always @(posedge clk) begin
        if (running && !rst) begin
            if (memReqValid) begin
                if (prevStalled) begin
                    checkMemReq(memReq, prevReq, "request changed while not ready");
                end
                if (memReqReady) begin
                    if (reqQ.size() == 0) begin
                        reportFailure("DUT issued a data-memory request the model did not make");
                    end else begin
                        checkMemReq(memReq, reqQ.pop_front(), "memory request payload");
                    end
                end
                prevStalled = !memReqReady;
                prevReq     = memReq;
            end else begin
                if (prevStalled) begin
                    reportFailure("memReqValid dropped before the request was accepted");
                end
                prevStalled = 1'b0;
            end
            if (outValid) begin
                if (wwdQ.size() == 0) begin
                    reportFailure("DUT produced a WWD output the model did not expect");
                end else begin
                    checkWord(outPort, wwdQ.pop_front(), "WWD output");
                end
            end
        end else begin
            prevStalled = 1'b0;
        end
    end

    initial begin
        rst         = 1'b1;
        running     = 1'b0;
        prevStalled = 1'b0;
        prevReq     = '0;
        retired     = '0;
        seed        = 32'ha6b98e30;
        for (int p = 0; p < 8; p++) begin
            runProgram(p, 20 + p * 6);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: sim.f
logic/cpuPkg.sv
logic/instrFetch.sv
logic/regFile.sv
logic/controlDecoder.sv
logic/alu.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/cpuCore.sv
verification/clockGen.sv
verification/dataMemModel.sv
verification/cpuTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the cpuTb simulation"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module cpuTb -o cpuTb
	@out=$$(obj_dir/cpuTb 2>&1); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
